/* hw/client_pkg.sv */
// Client side definitions
//   operation type of a client request
//   default number of clients

`default_nettype none

package client_pkg;

	// One request from a client is one of these
	typedef enum logic [1:0] {
		OP_READ    = 2'd0,
		OP_PROGRAM = 2'd1,
		OP_ERASE   = 2'd2
	} op_e;

	localparam int DEFAULT_NUM_CLIENTS = 2;

endpackage

`default_nettype wire

/* hw/flash_arbiter.sv */
// Round-robin arbiter for the flash clients
//   four-phase req/ack handshake per client
//   forwards the granted command to the flash driver
//   returns read data on a shared bus

`timescale 1ns/100ps
`default_nettype none

module flash_arbiter #(
	parameter int NUM_CLIENTS  = 2,
	parameter int FLASH_ADDR_W = 22
) (
	input  wire logic                                clk,
	input  wire logic                                arst_n,
	input  wire logic [NUM_CLIENTS-1:0]              client_req,
	input  wire client_pkg::op_e                     client_op [NUM_CLIENTS],
	input  wire logic [FLASH_ADDR_W-1:0]             client_addr [NUM_CLIENTS],
	input  wire logic [flash_pkg::FLASH_DATA_W-1:0]  client_wdata [NUM_CLIENTS],
	output logic [NUM_CLIENTS-1:0]                   client_ack,
	output logic [flash_pkg::FLASH_DATA_W-1:0]       client_rdata,
	output logic                                     cmd_valid,
	output client_pkg::op_e                          cmd_op,
	output logic [FLASH_ADDR_W-1:0]                  cmd_addr,
	output logic [flash_pkg::FLASH_DATA_W-1:0]       cmd_wdata,
	input  wire logic                                cmd_done,
	input  wire logic [flash_pkg::FLASH_DATA_W-1:0]  cmd_rdata
);
	localparam int IDX_W = (NUM_CLIENTS > 1) ? $clog2(NUM_CLIENTS) : 1;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_GRANT,
		ARB_BUSY,
		ARB_ACK
	} arb_state_e;

	arb_state_e state;

	// Client with the highest priority in the next round
	logic [IDX_W-1:0] rr_ptr;
	logic [IDX_W-1:0] grant_idx;
	logic [IDX_W-1:0] winner;

	// First requester at or after the pointer
	always_comb begin
		int unsigned idx;
		logic        found;

		found  = 1'b0;
		winner = rr_ptr;
		for (int i = 0; i < NUM_CLIENTS; i++) begin
			idx = (int'(rr_ptr) + i) % NUM_CLIENTS;
			if (!found && client_req[idx]) begin
				found  = 1'b1;
				winner = IDX_W'(idx);
			end
		end
	end

	// Client inputs are stable while req is high
	assign cmd_op    = client_op[grant_idx];
	assign cmd_addr  = client_addr[grant_idx];
	assign cmd_wdata = client_wdata[grant_idx];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= ARB_IDLE;
			rr_ptr     <= '0;
			grant_idx  <= '0;
			cmd_valid  <= 1'b0;
			client_ack <= '0;
		end else begin
			case (state)
				ARB_IDLE: begin
					if (|client_req) begin
						grant_idx <= winner;
						state     <= ARB_GRANT;
					end
				end
				ARB_GRANT: begin
					cmd_valid <= 1'b1;
					state     <= ARB_BUSY;
				end
				ARB_BUSY: begin
					if (cmd_done) begin
						cmd_valid             <= 1'b0;
						client_ack[grant_idx] <= 1'b1;
						state                 <= ARB_ACK;
					end
				end
				ARB_ACK: begin
					// Handshake closes when the client lets go of req
					if (!client_req[grant_idx]) begin
						client_ack <= '0;
						rr_ptr     <= (grant_idx == IDX_W'(NUM_CLIENTS - 1)) ? '0
							: grant_idx + 1'b1;
						state      <= ARB_IDLE;
					end
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == ARB_BUSY && cmd_done) begin
			client_rdata <= cmd_rdata;
		end
	end

endmodule

`default_nettype wire

/* hw/flash_driver.sv */
// NOR flash driver
//   turns one read, program or erase command into CFI bus cycles
//   polls the status register until the chip is ready
//   reports completion with a one-cycle done pulse

`timescale 1ns/100ps
`default_nettype none

module flash_driver #(
	parameter int FLASH_ADDR_W = 22
) (
	input  wire logic                                clk,
	input  wire logic                                arst_n,
	input  wire logic                                cmd_valid,
	input  wire client_pkg::op_e                     cmd_op,
	input  wire logic [FLASH_ADDR_W-1:0]             cmd_addr,
	input  wire logic [flash_pkg::FLASH_DATA_W-1:0]  cmd_wdata,
	output logic                                     cmd_done,
	output logic [flash_pkg::FLASH_DATA_W-1:0]       cmd_rdata,
	output logic [FLASH_ADDR_W-1:0]                  flash_addr,
	output logic [flash_pkg::FLASH_DATA_W-1:0]       flash_dq_out,
	output logic                                     flash_dq_oe,
	output logic                                     flash_we_n,
	output logic                                     flash_oe_n,
	input  wire logic [flash_pkg::FLASH_DATA_W-1:0]  flash_dq_in
);
	import flash_pkg::*;
	import client_pkg::*;

	// One state per bus cycle
	typedef enum logic [3:0] {
		IDLE      = 4'd0,
		RD_WE     = 4'd1,
		RD_REC    = 4'd2,
		RD_OE     = 4'd3,
		W1_WE     = 4'd4,
		W1_REC    = 4'd5,
		W2_WE     = 4'd6,
		W2_REC    = 4'd7,
		SR_WE     = 4'd8,
		SR_REC    = 4'd9,
		SR_OE     = 4'd10,
		SR_SAMPLE = 4'd11,
		DONE      = 4'd12
	} state_e;

	state_e state;
	state_e state_next;

	// Program data or erase confirm, whichever follows the first write
	logic [FLASH_DATA_W-1:0] second_word;
	logic                    status_ready;

	assign status_ready = flash_dq_in[SR_READY_BIT];

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (cmd_valid) begin
					case (cmd_op)
						OP_READ:              state_next = RD_WE;
						OP_PROGRAM, OP_ERASE: state_next = W1_WE;
						// Unknown op completes at once so the client is not stuck
						default:              state_next = DONE;
					endcase
				end
			end
			RD_WE:     state_next = RD_REC;
			RD_REC:    state_next = RD_OE;
			RD_OE:     state_next = DONE;
			W1_WE:     state_next = W1_REC;
			W1_REC:    state_next = W2_WE;
			W2_WE:     state_next = W2_REC;
			W2_REC:    state_next = SR_WE;
			SR_WE:     state_next = SR_REC;
			SR_REC:    state_next = SR_OE;
			SR_OE:     state_next = SR_SAMPLE;
			// Busy chip means another full poll
			SR_SAMPLE: state_next = status_ready ? DONE : SR_WE;
			DONE:      state_next = IDLE;
			default:   state_next = IDLE;
		endcase
	end

	// Pin levels are a registered decode of the next state
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state       <= IDLE;
			flash_we_n  <= 1'b1;
			flash_oe_n  <= 1'b1;
			flash_dq_oe <= 1'b0;
			cmd_done    <= 1'b0;
		end else begin
			state       <= state_next;
			flash_we_n  <= !(state_next inside {RD_WE, W1_WE, W2_WE, SR_WE});
			flash_oe_n  <= !(state_next inside {RD_OE, SR_OE, SR_SAMPLE});
			// Bus stays driven through the we_n rising cycle for data hold
			flash_dq_oe <= state_next inside {RD_WE, RD_REC, W1_WE, W1_REC,
				W2_WE, W2_REC, SR_WE, SR_REC};
			cmd_done    <= (state_next == DONE);
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && cmd_valid) begin
			flash_addr  <= cmd_addr;
			second_word <= (cmd_op == OP_PROGRAM) ? cmd_wdata : CMD_ERASE_CONFIRM;
		end

		case (state_next)
			RD_WE:   flash_dq_out <= CMD_READ_ARRAY;
			W1_WE:   flash_dq_out <= (cmd_op == OP_PROGRAM) ? CMD_PROGRAM : CMD_ERASE_SETUP;
			W2_WE:   flash_dq_out <= second_word;
			SR_WE:   flash_dq_out <= CMD_READ_STATUS;
			default: flash_dq_out <= flash_dq_out;
		endcase

		// Array word on reads, last status word on program and erase
		if (state == RD_OE || state == SR_SAMPLE) begin
			cmd_rdata <= flash_dq_in;
		end
	end

endmodule

`default_nettype wire

/* hw/flash_pkg.sv */
// Flash chip definitions shared by the driver and the flash model
//   data bus width
//   Intel/CFI command codes
//   status register ready bit

`default_nettype none

package flash_pkg;

	// Parallel data bus of the flash chip
	localparam int FLASH_DATA_W = 16;

	// CFI command words, written on the low byte of the bus
	localparam logic [FLASH_DATA_W-1:0] CMD_READ_ARRAY    = 16'h00FF;
	localparam logic [FLASH_DATA_W-1:0] CMD_PROGRAM       = 16'h0040;
	localparam logic [FLASH_DATA_W-1:0] CMD_ERASE_SETUP   = 16'h0020;
	localparam logic [FLASH_DATA_W-1:0] CMD_ERASE_CONFIRM = 16'h00D0;
	localparam logic [FLASH_DATA_W-1:0] CMD_READ_STATUS   = 16'h0070;

	// Set by the chip when the write state machine is idle
	localparam int SR_READY_BIT = 7;

endpackage

`default_nettype wire

/* hw/flash_subsystem.sv */
// Shared flash controller top level
//   round-robin arbiter for the clients
//   CFI flash driver on the chip pins

`timescale 1ns/100ps
`default_nettype none

module flash_subsystem #(
	parameter int FLASH_ADDR_W = 22,
	parameter int NUM_CLIENTS  = client_pkg::DEFAULT_NUM_CLIENTS
) (
	input  wire logic                                clk,
	input  wire logic                                arst_n,
	input  wire logic [NUM_CLIENTS-1:0]              client_req,
	input  wire client_pkg::op_e                     client_op [NUM_CLIENTS],
	input  wire logic [FLASH_ADDR_W-1:0]             client_addr [NUM_CLIENTS],
	input  wire logic [flash_pkg::FLASH_DATA_W-1:0]  client_wdata [NUM_CLIENTS],
	output logic [NUM_CLIENTS-1:0]                   client_ack,
	output logic [flash_pkg::FLASH_DATA_W-1:0]       client_rdata,
	output logic [FLASH_ADDR_W-1:0]                  flash_addr,
	output logic [flash_pkg::FLASH_DATA_W-1:0]       flash_dq_out,
	output logic                                     flash_dq_oe,
	output logic                                     flash_we_n,
	output logic                                     flash_oe_n,
	input  wire logic [flash_pkg::FLASH_DATA_W-1:0]  flash_dq_in
);
	import flash_pkg::*;
	import client_pkg::*;

	// Arbiter to driver command path
	logic                    cmd_valid;
	op_e                     cmd_op;
	logic [FLASH_ADDR_W-1:0] cmd_addr;
	logic [FLASH_DATA_W-1:0] cmd_wdata;
	logic                    cmd_done;
	logic [FLASH_DATA_W-1:0] cmd_rdata;

	flash_arbiter #(
		.NUM_CLIENTS  (NUM_CLIENTS),
		.FLASH_ADDR_W (FLASH_ADDR_W)
	) flash_arbiter_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.client_req   (client_req),
		.client_op    (client_op),
		.client_addr  (client_addr),
		.client_wdata (client_wdata),
		.client_ack   (client_ack),
		.client_rdata (client_rdata),
		.cmd_valid    (cmd_valid),
		.cmd_op       (cmd_op),
		.cmd_addr     (cmd_addr),
		.cmd_wdata    (cmd_wdata),
		.cmd_done     (cmd_done),
		.cmd_rdata    (cmd_rdata)
	);

	flash_driver #(
		.FLASH_ADDR_W (FLASH_ADDR_W)
	) flash_driver_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.cmd_valid    (cmd_valid),
		.cmd_op       (cmd_op),
		.cmd_addr     (cmd_addr),
		.cmd_wdata    (cmd_wdata),
		.cmd_done     (cmd_done),
		.cmd_rdata    (cmd_rdata),
		.flash_addr   (flash_addr),
		.flash_dq_out (flash_dq_out),
		.flash_dq_oe  (flash_dq_oe),
		.flash_we_n   (flash_we_n),
		.flash_oe_n   (flash_oe_n),
		.flash_dq_in  (flash_dq_in)
	);

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the flash subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 \
	--top-module flash_subsystem_tb \
	-f sources.f \
	-Mdir obj_dir
./obj_dir/Vflash_subsystem_tb

/* sources.f */
hw/flash_pkg.sv
hw/client_pkg.sv
hw/flash_driver.sv
hw/flash_arbiter.sv
hw/flash_subsystem.sv
tb/flash_model.sv
tb/flash_subsystem_assertions.sv
tb/flash_subsystem_tb.sv

/* tb/flash_model.sv */
// Behavioral NOR flash chip
//   sparse word array, erased words read as all ones
//   program clears bits only, block erase sets a block back to ones
//   status register with a busy period counted in status reads

`timescale 1ns/100ps
`default_nettype none

module flash_model #(
	parameter int ADDR_W = 22
) (
	input  wire logic                                clk,
	input  wire logic                                arst_n,
	input  wire logic [ADDR_W-1:0]                   flash_addr,
	input  wire logic [flash_pkg::FLASH_DATA_W-1:0]  flash_dq_out,
	input  wire logic                                flash_dq_oe,
	input  wire logic                                flash_we_n,
	input  wire logic                                flash_oe_n,
	output logic [flash_pkg::FLASH_DATA_W-1:0]       flash_dq_in
);
	import flash_pkg::*;

	localparam int BLOCK_WORDS = 256;
	localparam int BUSY_POLLS  = 3;

	// What the next bus write means
	typedef enum logic [1:0] {
		EXPECT_CMD,
		EXPECT_DATA,
		EXPECT_CONFIRM
	} phase_e;

	logic [FLASH_DATA_W-1:0] mem [int];
	logic                    status_mode;
	phase_e                  phase;
	int                      busy_left;
	logic                    oe_n_prev;

	function automatic logic [FLASH_DATA_W-1:0] word_at(input int key);
		if (mem.exists(key)) begin
			return mem[key];
		end
		return '1;
	endfunction

	task automatic erase_block(input int block);
		int doomed [$];
		foreach (mem[key]) begin
			if (key / BLOCK_WORDS == block) begin
				doomed.push_back(key);
			end
		end
		foreach (doomed[k]) begin
			mem.delete(doomed[k]);
		end
	endtask

	always_comb begin
		flash_dq_in = '0;
		if (!flash_oe_n) begin
			if (status_mode) begin
				flash_dq_in[SR_READY_BIT] = (busy_left == 0);
			end else if (mem.exists(int'(flash_addr))) begin
				flash_dq_in = mem[int'(flash_addr)];
			end else begin
				flash_dq_in = '1;
			end
		end
	end

	always @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			status_mode <= 1'b0;
			phase       <= EXPECT_CMD;
			busy_left   <= 0;
			oe_n_prev   <= 1'b1;
		end else begin
			oe_n_prev <= flash_oe_n;
			// One busy poll used up at the end of each status read
			if (!oe_n_prev && flash_oe_n && status_mode && busy_left > 0) begin
				busy_left <= busy_left - 1;
			end
			if (!flash_we_n && flash_dq_oe) begin
				case (phase)
					EXPECT_DATA: begin
						mem[int'(flash_addr)] = word_at(int'(flash_addr)) & flash_dq_out;
						busy_left <= BUSY_POLLS;
						phase     <= EXPECT_CMD;
					end
					EXPECT_CONFIRM: begin
						if (flash_dq_out == CMD_ERASE_CONFIRM) begin
							erase_block(int'(flash_addr) / BLOCK_WORDS);
							busy_left <= BUSY_POLLS;
						end
						phase <= EXPECT_CMD;
					end
					default: begin
						case (flash_dq_out)
							CMD_READ_ARRAY:  status_mode <= 1'b0;
							CMD_READ_STATUS: status_mode <= 1'b1;
							CMD_PROGRAM: begin
								status_mode <= 1'b1;
								phase       <= EXPECT_DATA;
							end
							CMD_ERASE_SETUP: begin
								status_mode <= 1'b1;
								phase       <= EXPECT_CONFIRM;
							end
							default: ;
						endcase
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* tb/flash_patterns.txt */
// client op address wdata expected; client 10 and 11 mark the two lines of a same-cycle pair
// op 0 read, 1 program, 2 erase; expected is array data on reads, final status word otherwise
10 0 000010 0000 ffff
11 0 000020 0000 ffff
0 1 000100 1234 0080
1 0 000100 0000 1234
1 1 000100 ff0f 0080
0 0 000100 0000 1204
0 1 000105 a5a5 0080
1 1 000200 5a5a 0080
1 0 000105 0000 a5a5
1 2 000180 0000 0080
0 0 000100 0000 ffff
1 0 000105 0000 ffff
0 0 000200 0000 5a5a
10 0 000200 0000 5a5a
11 0 000105 0000 ffff

/* tb/flash_subsystem_assertions.sv */
// Concurrent checks on the flash subsystem
//   one client ack at a time, ack only after its req
//   flash_we_n and flash_oe_n never low together

`timescale 1ns/100ps
`default_nettype none

module flash_subsystem_assertions #(
	parameter int NUM_CLIENTS = 2
) (
	input wire logic                   clk,
	input wire logic                   arst_n,
	input wire logic [NUM_CLIENTS-1:0] client_req,
	input wire logic [NUM_CLIENTS-1:0] client_ack,
	input wire logic                   flash_we_n,
	input wire logic                   flash_oe_n
);
	single_ack: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(client_ack))
		else $error("more than one client ack is high");

	for (genvar i = 0; i < NUM_CLIENTS; i++) begin : g_ack
		ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
			$rose(client_ack[i]) |-> $past(client_req[i]))
			else $error("ack of client %0d rose without its req", i);
	end

	no_bus_clash: assert property (@(posedge clk) disable iff (!arst_n)
		!(!flash_we_n && !flash_oe_n))
		else $error("flash_we_n and flash_oe_n are low together");

endmodule

bind flash_subsystem flash_subsystem_assertions #(
	.NUM_CLIENTS (NUM_CLIENTS)
) flash_subsystem_assertions_inst (
	.clk        (clk),
	.arst_n     (arst_n),
	.client_req (client_req),
	.client_ack (client_ack),
	.flash_we_n (flash_we_n),
	.flash_oe_n (flash_oe_n)
);

`default_nettype wire

/* tb/flash_subsystem_tb.sv */
// Testbench for the shared flash controller
//   clock, reset and cycle limit
//   transactions read from the pattern file
//   four-phase handshake per client with data and order checks

`timescale 1ns/100ps
`default_nettype none

module flash_subsystem_tb;
	import flash_pkg::*;
	import client_pkg::*;

	localparam int NUM_CLIENTS        = 2;
	localparam int FLASH_ADDR_W       = 22;
	localparam int MAX_PATTERNS       = 32;
	localparam int PATTERN_COLS       = 5;
	localparam int CYCLES_PER_PATTERN = 80;
	localparam logic [31:0] PAIR_FLAG = 32'h10;

	logic                    clk;
	logic                    arst_n;
	logic [NUM_CLIENTS-1:0]  client_req;
	op_e                     client_op [NUM_CLIENTS];
	logic [FLASH_ADDR_W-1:0] client_addr [NUM_CLIENTS];
	logic [FLASH_DATA_W-1:0] client_wdata [NUM_CLIENTS];
	logic [NUM_CLIENTS-1:0]  client_ack;
	logic [FLASH_DATA_W-1:0] client_rdata;
	logic [FLASH_ADDR_W-1:0] flash_addr;
	logic [FLASH_DATA_W-1:0] flash_dq_out;
	logic                    flash_dq_oe;
	logic                    flash_we_n;
	logic                    flash_oe_n;
	logic [FLASH_DATA_W-1:0] flash_dq_in;

	// Five words per transaction as client, op, address, write data and expected
	logic [31:0] patterns [MAX_PATTERNS*PATTERN_COLS];
	int          num_patterns;
	int          timeout_cycles = MAX_PATTERNS * CYCLES_PER_PATTERN + 20;
	int          cycle_count = 0;
	int          seed = 32'hc835_4187;
	int          ack_order [$];
	int          next_first;

	flash_subsystem #(
		.FLASH_ADDR_W (FLASH_ADDR_W),
		.NUM_CLIENTS  (NUM_CLIENTS)
	) flash_subsystem_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.client_req   (client_req),
		.client_op    (client_op),
		.client_addr  (client_addr),
		.client_wdata (client_wdata),
		.client_ack   (client_ack),
		.client_rdata (client_rdata),
		.flash_addr   (flash_addr),
		.flash_dq_out (flash_dq_out),
		.flash_dq_oe  (flash_dq_oe),
		.flash_we_n   (flash_we_n),
		.flash_oe_n   (flash_oe_n),
		.flash_dq_in  (flash_dq_in)
	);

	flash_model #(
		.ADDR_W (FLASH_ADDR_W)
	) flash_model_inst (
		.clk          (clk),
		.arst_n       (arst_n),
		.flash_addr   (flash_addr),
		.flash_dq_out (flash_dq_out),
		.flash_dq_oe  (flash_dq_oe),
		.flash_we_n   (flash_we_n),
		.flash_oe_n   (flash_oe_n),
		.flash_dq_in  (flash_dq_in)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Simulation failed");
		$fatal(1, "run aborted");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("** Error: %s is 0x%0h, expected 0x%0h", name, got, expected);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			abort_run($sformatf("No progress: cycle limit of %0d reached", timeout_cycles));
		end
	end

	// Starts one cycle phase after a rising edge and returns with ack low again
	task automatic run_transaction(input int c, input logic [31:0] op,
		input logic [31:0] addr, input logic [31:0] wdata, input logic [31:0] expected);
		int                      hold;
		logic [FLASH_DATA_W-1:0] held_rdata;
		client_op[c]    = op_e'(op[1:0]);
		client_addr[c]  = addr[FLASH_ADDR_W-1:0];
		client_wdata[c] = wdata[FLASH_DATA_W-1:0];
		client_req[c]   = 1'b1;
		while (!client_ack[c]) begin
			@(posedge clk);
			#1;
		end
		ack_order.push_back(c);
		check_value("client_rdata", 32'(client_rdata), expected);
		held_rdata = client_rdata;
		// Keep the handshake open for a few cycles of back-pressure
		hold = $unsigned($random(seed)) % 8;
		repeat (hold) begin
			@(posedge clk);
			#1;
			check_value("client_ack", 32'(client_ack[c]), 32'd1);
			check_value("client_rdata", 32'(client_rdata), 32'(held_rdata));
		end
		client_req[c] = 1'b0;
		while (client_ack[c]) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic issue_line(input int line);
		int base;
		base = line * PATTERN_COLS;
		run_transaction(int'(patterns[base][3:0]), patterns[base+1], patterns[base+2],
			patterns[base+3], patterns[base+4]);
	endtask

	initial begin
		int i;
		arst_n     = 1'b0;
		client_req = '0;
		for (int c = 0; c < NUM_CLIENTS; c++) begin
			client_op[c]    = OP_READ;
			client_addr[c]  = '0;
			client_wdata[c] = '0;
		end
		foreach (patterns[k]) begin
			patterns[k] = '1;
		end
		$readmemh("tb/flash_patterns.txt", patterns);
		num_patterns = 0;
		while (num_patterns < MAX_PATTERNS && patterns[num_patterns*PATTERN_COLS] != '1) begin
			num_patterns++;
		end
		if (num_patterns == 0) begin
			abort_run("The pattern file holds no transactions");
		end
		timeout_cycles = num_patterns * CYCLES_PER_PATTERN + 20;

		repeat (5) @(posedge clk);
		#1;
		arst_n     = 1'b1;
		next_first = 0;
		i          = 0;
		while (i < num_patterns) begin
			ack_order.delete();
			if ((patterns[i*PATTERN_COLS] & PAIR_FLAG) != 0) begin
				if (i + 1 >= num_patterns || (patterns[(i+1)*PATTERN_COLS] & PAIR_FLAG) == 0) begin
					abort_run($sformatf("Pattern line %0d is a pair without a partner", i));
				end
				// Both clients raise req in the same cycle
				fork
					issue_line(i);
					issue_line(i + 1);
				join
				check_value("first ack client", 32'(ack_order[0]), 32'(next_first));
				// Pointer moves past both served clients
				next_first = (next_first + 2) % NUM_CLIENTS;
				i += 2;
			end else begin
				issue_line(i);
				next_first = (int'(patterns[i*PATTERN_COLS][3:0]) + 1) % NUM_CLIENTS;
				i += 1;
			end
		end

		@(posedge clk);
		#1;
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire
